/* project.f */
ooo_pkg.sv
dispatch_unit.sv
exec_lane.sv
cdb_arbiter.sv
rob.sv
ooo_backend.sv
tb_ooo_backend.sv

/* Bender.yml */
package:
  name: ooo_backend

sources:
  # shared package first
  - ooo_pkg.sv
  # design
  - dispatch_unit.sv
  - exec_lane.sv
  - cdb_arbiter.sv
  - rob.sv
  - ooo_backend.sv
  # testbench
  - target: test
    files:
      - tb_ooo_backend.sv

/* tb_ooo_backend.sv */
`timescale 1ns/10ps

module tb_ooo_backend
    import ooo_pkg::*;
();

    localparam int NUM_UOPS    = 400;
    localparam int STALL_LIMIT = 200;
    localparam int DRAIN_LIMIT = 2000;

    logic               clk;
    logic               rst;
    logic               dispatch_valid;
    alu_op_e            dispatch_op;
    logic [XLEN-1:0]    dispatch_a;
    logic [XLEN-1:0]    dispatch_b;
    logic [REG_W-1:0]   dispatch_rd;
    logic               dispatch_ready;
    logic               commit_valid;
    logic [REG_W-1:0]   commit_rd;
    logic [XLEN-1:0]    commit_value;
    logic [ORDER_W-1:0] commit_order;

    // reference model state
    logic [REG_W-1:0]   exp_rd_q  [$];
    logic [XLEN-1:0]    exp_val_q [$];
    logic [ORDER_W-1:0] exp_order = '0;
    int                 inflight = 0;
    int                 full_cycles = 0;

    ooo_backend i_dut (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .dispatch_a     (dispatch_a),
        .dispatch_b     (dispatch_b),
        .dispatch_rd    (dispatch_rd),
        .dispatch_ready (dispatch_ready),
        .commit_valid   (commit_valid),
        .commit_rd      (commit_rd),
        .commit_value   (commit_value),
        .commit_order   (commit_order)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // expected result of one micro-op
    // x0 always commits zero
    function automatic logic [XLEN-1:0] model_result(
        input alu_op_e          op,
        input logic [XLEN-1:0]  a,
        input logic [XLEN-1:0]  b,
        input logic [REG_W-1:0] rd
    );
        logic [2*XLEN-1:0] wide;
        logic [XLEN-1:0]   res;
        wide = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        case (op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_XOR:  res = a ^ b;
            OP_SLL:  res = a << b[4:0];
            OP_MUL:  res = wide[XLEN-1:0];
            default: res = '0;
        endcase
        if (rd == '0) begin
            res = '0;
        end
        return res;
    endfunction

    // x0 now and then or else any other register
    function automatic logic [REG_W-1:0] pick_rd();
        if ($urandom_range(0, 7) == 0) begin
            return '0;
        end
        return REG_W'($urandom_range(1, 31));
    endfunction

    function automatic alu_op_e pick_simple_op();
        return alu_op_e'($urandom_range(0, 4));
    endfunction

    task automatic compare_value(
        input string           test,
        input logic [XLEN-1:0] expected,
        input logic [XLEN-1:0] actual
    );
        assert (expected === actual) else begin
            $display("ERR %s expected %0h actual %0h", test, expected, actual);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    // hold the micro-op until the DUT takes it
    task automatic send_uop(
        input alu_op_e          op,
        input logic [XLEN-1:0]  a,
        input logic [XLEN-1:0]  b,
        input logic [REG_W-1:0] rd
    );
        int   waited;
        logic taken;
        waited         = 0;
        taken          = 1'b0;
        dispatch_valid = 1'b1;
        dispatch_op    = op;
        dispatch_a     = a;
        dispatch_b     = b;
        dispatch_rd    = rd;
        while (!taken) begin
            @(negedge clk);
            taken = dispatch_ready;
            @(posedge clk);
            #1;
            waited++;
            assert (taken || waited < STALL_LIMIT) else begin
                $display("dispatch stalled too long, micro-op never accepted");
                $display("Simulation FAILED");
                $fatal(1);
            end
        end
        dispatch_valid = 1'b0;
    endtask

    // model and commit monitor
    // sampled mid-cycle where outputs are settled
    always @(negedge clk) begin : monitor
        logic [REG_W-1:0] rd_e;
        logic [XLEN-1:0]  val_e;
        if (!rst) begin
            assert (inflight <= ROB_DEPTH) else begin
                $display("more micro-ops in flight than the rob can hold");
                $display("Simulation FAILED");
                $fatal(1);
            end
            if (inflight == ROB_DEPTH) begin
                full_cycles++;
                compare_value("full_rob_blocks_dispatch", 0, dispatch_ready);
            end
            if (commit_valid) begin
                assert (exp_rd_q.size() > 0) else begin
                    $display("commit seen with no micro-op outstanding");
                    $display("Simulation FAILED");
                    $fatal(1);
                end
                rd_e  = exp_rd_q.pop_front();
                val_e = exp_val_q.pop_front();
                compare_value("commit_order", exp_order, commit_order);
                compare_value("commit_rd", rd_e, commit_rd);
                if (rd_e == '0) begin
                    compare_value("commit_x0_zero", val_e, commit_value);
                end else begin
                    compare_value("commit_value", val_e, commit_value);
                end
                exp_order++;
                inflight--;
            end
            if (dispatch_valid && dispatch_ready) begin
                exp_rd_q.push_back(dispatch_rd);
                exp_val_q.push_back(model_result(dispatch_op, dispatch_a, dispatch_b,
                                                 dispatch_rd));
                inflight++;
            end
        end
    end

    initial begin : stimulus
        int sent;
        int waited;
        void'($urandom(32'h6cde));
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_op    = OP_ADD;
        dispatch_a     = '0;
        dispatch_b     = '0;
        dispatch_rd    = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        @(negedge clk);
        compare_value("reset_commit_valid", 0, commit_valid);
        compare_value("reset_dispatch_ready", 1, dispatch_ready);
        @(posedge clk);
        #1;

        sent = 0;
        while (sent < NUM_UOPS) begin
            if ($urandom_range(0, 9) == 0) begin
                // slow head with quick ops behind it fills the rob
                send_uop(OP_MUL, $urandom, $urandom, pick_rd());
                sent++;
                repeat (10) begin
                    send_uop(pick_simple_op(), $urandom, $urandom, pick_rd());
                    sent++;
                end
            end else if ($urandom_range(0, 9) == 0) begin
                // multiply burst keeps all lanes busy
                repeat (6) begin
                    send_uop(OP_MUL, $urandom, $urandom, pick_rd());
                    sent++;
                end
            end else begin
                send_uop(alu_op_e'($urandom_range(0, 5)), $urandom, $urandom, pick_rd());
                sent++;
                if ($urandom_range(0, 2) == 0) begin
                    repeat ($urandom_range(1, 4)) begin
                        @(posedge clk);
                        #1;
                    end
                end
            end
        end

        // drain everything still in flight
        waited = 0;
        while (exp_rd_q.size() > 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        assert (exp_rd_q.size() == 0) else begin
            $display("drain timed out with %0d micro-ops not committed", exp_rd_q.size());
            $display("Simulation FAILED");
            $fatal(1);
        end

        // quiet period where any stray commit trips the monitor
        repeat (20) @(posedge clk);
        // order counter steps exactly once per micro-op sent
        compare_value("commit_count", ORDER_W'(sent), commit_order);
        assert (full_cycles > 0) else begin
            $display("the rob never filled during the run");
            $display("Simulation FAILED");
            $fatal(1);
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule : tb_ooo_backend

/* ooo_backend.sv */
`timescale 1ns/10ps

module ooo_backend
    import ooo_pkg::*;
(
    input  logic               clk,
    input  logic               rst,

    // dispatch port
    input  logic               dispatch_valid,
    input  alu_op_e            dispatch_op,
    input  logic [XLEN-1:0]    dispatch_a,
    input  logic [XLEN-1:0]    dispatch_b,
    input  logic [REG_W-1:0]   dispatch_rd,
    output logic               dispatch_ready,

    // commit port
    output logic               commit_valid,
    output logic [REG_W-1:0]   commit_rd,
    output logic [XLEN-1:0]    commit_value,
    output logic [ORDER_W-1:0] commit_order
);

    // allocation
    logic                 alloc_ready;
    logic [ROB_IDX_W-1:0] alloc_idx;
    logic                 alloc_valid;
    logic [REG_W-1:0]     alloc_rd;

    // issue
    logic [NUM_LANES-1:0] lane_idle;
    logic [NUM_LANES-1:0] issue_valid;
    alu_op_e              issue_op;
    logic [XLEN-1:0]      issue_a;
    logic [XLEN-1:0]      issue_b;
    logic [ROB_IDX_W-1:0] issue_rob_idx;

    // common data bus
    logic [NUM_LANES-1:0] cdb_req;
    logic [NUM_LANES-1:0] cdb_grant;
    logic [XLEN-1:0]      lane_result  [NUM_LANES];
    logic [ROB_IDX_W-1:0] lane_rob_idx [NUM_LANES];
    logic                 wb_valid;
    logic [ROB_IDX_W-1:0] wb_idx;
    logic [XLEN-1:0]      wb_value;

    dispatch_unit i_dispatch (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .dispatch_a     (dispatch_a),
        .dispatch_b     (dispatch_b),
        .dispatch_rd    (dispatch_rd),
        .dispatch_ready (dispatch_ready),
        .alloc_ready    (alloc_ready),
        .alloc_idx      (alloc_idx),
        .alloc_valid    (alloc_valid),
        .alloc_rd       (alloc_rd),
        .lane_idle      (lane_idle),
        .issue_valid    (issue_valid),
        .issue_op       (issue_op),
        .issue_a        (issue_a),
        .issue_b        (issue_b),
        .issue_rob_idx  (issue_rob_idx)
    );

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        exec_lane i_lane (
            .clk         (clk),
            .rst         (rst),
            .start       (issue_valid[g]),
            .op          (issue_op),
            .a           (issue_a),
            .b           (issue_b),
            .rob_idx     (issue_rob_idx),
            .idle        (lane_idle[g]),
            .grant       (cdb_grant[g]),
            .req         (cdb_req[g]),
            .result      (lane_result[g]),
            .res_rob_idx (lane_rob_idx[g])
        );
    end

    cdb_arbiter i_arbiter (
        .clk          (clk),
        .rst          (rst),
        .req          (cdb_req),
        .lane_result  (lane_result),
        .lane_rob_idx (lane_rob_idx),
        .grant        (cdb_grant),
        .wb_valid     (wb_valid),
        .wb_idx       (wb_idx),
        .wb_value     (wb_value)
    );

    rob i_rob (
        .clk          (clk),
        .rst          (rst),
        .alloc_valid  (alloc_valid),
        .alloc_rd     (alloc_rd),
        .alloc_ready  (alloc_ready),
        .alloc_idx    (alloc_idx),
        .wb_valid     (wb_valid),
        .wb_idx       (wb_idx),
        .wb_value     (wb_value),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_value (commit_value),
        .commit_order (commit_order)
    );

endmodule : ooo_backend

/* rob.sv */
`timescale 1ns/10ps

module rob
    import ooo_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,

    // allocation from dispatch
    input  logic                 alloc_valid,
    input  logic [REG_W-1:0]     alloc_rd,
    output logic                 alloc_ready,
    output logic [ROB_IDX_W-1:0] alloc_idx,

    // writeback from the common data bus
    input  logic                 wb_valid,
    input  logic [ROB_IDX_W-1:0] wb_idx,
    input  logic [XLEN-1:0]      wb_value,

    // in-order commit
    output logic                 commit_valid,
    output logic [REG_W-1:0]     commit_rd,
    output logic [XLEN-1:0]      commit_value,
    output logic [ORDER_W-1:0]   commit_order
);

    // per-entry state
    logic [ROB_DEPTH-1:0] entry_valid;
    logic [ROB_DEPTH-1:0] entry_done;
    logic [REG_W-1:0]     entry_rd    [ROB_DEPTH];
    logic [XLEN-1:0]      entry_value [ROB_DEPTH];

    logic [ROB_IDX_W-1:0] head;
    logic [ROB_IDX_W-1:0] tail;
    logic [ROB_IDX_W:0]   count;
    logic [ORDER_W-1:0]   order_cnt;

    logic                 alloc_fire;
    logic                 commit_fire;

    function automatic logic [ROB_IDX_W-1:0] ptr_inc(input logic [ROB_IDX_W-1:0] p);
        if (p == ROB_IDX_W'(ROB_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    // registered count, a same-cycle commit does not free a slot
    assign alloc_ready = (count < (ROB_IDX_W + 1)'(ROB_DEPTH));
    assign alloc_idx   = tail;
    assign alloc_fire  = alloc_valid && alloc_ready;

    // head commits once its writeback has landed
    assign commit_valid = entry_valid[head] && entry_done[head];
    assign commit_rd    = entry_rd[head];
    assign commit_value = entry_value[head];
    assign commit_order = order_cnt;
    assign commit_fire  = commit_valid;

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            entry_valid <= '0;
            entry_done  <= '0;
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            order_cnt   <= '0;
        end else begin
            if (alloc_fire) begin
                entry_valid[tail] <= 1'b1;
                entry_done[tail]  <= 1'b0;
                tail              <= ptr_inc(tail);
            end

            if (wb_valid) begin
                entry_done[wb_idx] <= 1'b1;
            end

            // head and tail never coincide here, alloc is blocked when full
            if (commit_fire) begin
                entry_valid[head] <= 1'b0;
                entry_done[head]  <= 1'b0;
                head              <= ptr_inc(head);
                order_cnt         <= order_cnt + 1'b1;
            end

            case ({alloc_fire, commit_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            entry_rd[tail] <= alloc_rd;
        end
        if (wb_valid) begin
            // x0 always reads back as zero
            if (entry_rd[wb_idx] == '0) begin
                entry_value[wb_idx] <= '0;
            end else begin
                entry_value[wb_idx] <= wb_value;
            end
        end
    end

    a_wb_target_pending: assert property (
        @(posedge clk) disable iff (rst)
        wb_valid |-> (entry_valid[wb_idx] && !entry_done[wb_idx])
    );

    a_alloc_not_full: assert property (
        @(posedge clk) disable iff (rst)
        alloc_valid |-> alloc_ready
    );

endmodule : rob

/* cdb_arbiter.sv */
`timescale 1ns/10ps

module cdb_arbiter
    import ooo_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,

    // lane requests and payloads
    input  logic [NUM_LANES-1:0] req,
    input  logic [XLEN-1:0]      lane_result  [NUM_LANES],
    input  logic [ROB_IDX_W-1:0] lane_rob_idx [NUM_LANES],
    output logic [NUM_LANES-1:0] grant,

    // writeback to the rob
    output logic                 wb_valid,
    output logic [ROB_IDX_W-1:0] wb_idx,
    output logic [XLEN-1:0]      wb_value
);

    logic [LANE_IDX_W-1:0] prio_ptr;
    logic [LANE_IDX_W-1:0] win_lane;

    // first requester at or after the priority pointer
    always_comb begin
        int cand;
        win_lane = prio_ptr;
        for (int k = NUM_LANES - 1; k >= 0; k--) begin
            cand = (int'(prio_ptr) + k) % NUM_LANES;
            if (req[cand]) begin
                win_lane = LANE_IDX_W'(cand);
            end
        end
    end

    assign wb_valid = |req;
    assign grant    = wb_valid ? (NUM_LANES'(1) << win_lane) : '0;
    assign wb_idx   = lane_rob_idx[win_lane];
    assign wb_value = lane_result[win_lane];

    // rotate so a waiting multiply is not starved by quick results
    always_ff @(posedge clk) begin
        if (rst) begin
            prio_ptr <= '0;
        end else if (wb_valid) begin
            if (win_lane == LANE_IDX_W'(NUM_LANES - 1)) begin
                prio_ptr <= '0;
            end else begin
                prio_ptr <= win_lane + 1'b1;
            end
        end
    end

    a_grant_onehot_subset: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(grant) && ((grant & ~req) == '0)
    );

endmodule : cdb_arbiter

/* exec_lane.sv */
`timescale 1ns/10ps

module exec_lane
    import ooo_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,

    // issue side
    input  logic                 start,
    input  alu_op_e              op,
    input  logic [XLEN-1:0]      a,
    input  logic [XLEN-1:0]      b,
    input  logic [ROB_IDX_W-1:0] rob_idx,
    output logic                 idle,

    // common data bus side
    input  logic                 grant,
    output logic                 req,
    output logic [XLEN-1:0]      result,
    output logic [ROB_IDX_W-1:0] res_rob_idx
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,
        ST_WAIT
    } lane_state_e;

    lane_state_e      state;
    logic [CNT_W-1:0] cnt;

    function automatic logic [XLEN-1:0] alu_eval(
        input alu_op_e         f_op,
        input logic [XLEN-1:0] f_a,
        input logic [XLEN-1:0] f_b
    );
        logic [2*XLEN-1:0] prod;
        prod = f_a * f_b;
        case (f_op)
            OP_ADD:  return f_a + f_b;
            OP_SUB:  return f_a - f_b;
            OP_AND:  return f_a & f_b;
            OP_XOR:  return f_a ^ f_b;
            OP_SLL:  return f_a << f_b[4:0];
            OP_MUL:  return prod[XLEN-1:0];
            default: return '0;
        endcase
    endfunction

    assign idle = (state == ST_IDLE);
    assign req  = (state == ST_WAIT);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state <= ST_BUSY;
                        cnt   <= (op == OP_MUL) ? CNT_W'(MUL_LATENCY) : CNT_W'(1);
                    end
                end
                ST_BUSY: begin
                    cnt <= cnt - 1'b1;
                    // last cycle of the countdown
                    if (cnt == CNT_W'(1)) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (grant) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // result is known at capture
    // the countdown only models latency
    always_ff @(posedge clk) begin
        if (start) begin
            result      <= alu_eval(op, a, b);
            res_rob_idx <= rob_idx;
        end
    end

    a_start_when_idle: assert property (
        @(posedge clk) disable iff (rst)
        start |-> (state == ST_IDLE)
    );

endmodule : exec_lane

/* dispatch_unit.sv */
`timescale 1ns/10ps

module dispatch_unit
    import ooo_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,

    // external dispatch port
    input  logic                 dispatch_valid,
    input  alu_op_e              dispatch_op,
    input  logic [XLEN-1:0]      dispatch_a,
    input  logic [XLEN-1:0]      dispatch_b,
    input  logic [REG_W-1:0]     dispatch_rd,
    output logic                 dispatch_ready,

    // rob allocation
    input  logic                 alloc_ready,
    input  logic [ROB_IDX_W-1:0] alloc_idx,
    output logic                 alloc_valid,
    output logic [REG_W-1:0]     alloc_rd,

    // lane issue
    input  logic [NUM_LANES-1:0] lane_idle,
    output logic [NUM_LANES-1:0] issue_valid,
    output alu_op_e              issue_op,
    output logic [XLEN-1:0]      issue_a,
    output logic [XLEN-1:0]      issue_b,
    output logic [ROB_IDX_W-1:0] issue_rob_idx
);

    logic [LANE_IDX_W-1:0] rr_ptr;
    logic [LANE_IDX_W-1:0] sel_lane;
    logic                  any_idle;
    logic                  accept;

    // first idle lane at or after the round-robin pointer
    always_comb begin
        int cand;
        sel_lane = rr_ptr;
        any_idle = 1'b0;
        // walk downward so the closest lane to the pointer wins
        for (int k = NUM_LANES - 1; k >= 0; k--) begin
            cand = (int'(rr_ptr) + k) % NUM_LANES;
            if (lane_idle[cand]) begin
                sel_lane = LANE_IDX_W'(cand);
                any_idle = 1'b1;
            end
        end
    end

    assign dispatch_ready = alloc_ready && any_idle;
    assign accept         = dispatch_valid && dispatch_ready;

    // slot request to the rob
    assign alloc_valid = accept;
    assign alloc_rd    = dispatch_rd;

    // shared issue buses, one-hot start strobe
    assign issue_valid   = accept ? (NUM_LANES'(1) << sel_lane) : '0;
    assign issue_op      = dispatch_op;
    assign issue_a       = dispatch_a;
    assign issue_b       = dispatch_b;
    assign issue_rob_idx = alloc_idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr <= '0;
        end else if (accept) begin
            // move past the lane just used
            if (sel_lane == LANE_IDX_W'(NUM_LANES - 1)) begin
                rr_ptr <= '0;
            end else begin
                rr_ptr <= sel_lane + 1'b1;
            end
        end
    end

    // one lane at a time, and only a lane that was idle; it leaves idle next cycle
    a_issue_onehot_idle: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(issue_valid) && ((issue_valid & ~lane_idle) == '0)
    );

    a_issue_lane_busy: assert property (
        @(posedge clk) disable iff (rst)
        (|issue_valid) |=> ((lane_idle & $past(issue_valid)) == '0)
    );

endmodule : dispatch_unit

/* ooo_pkg.sv */
package ooo_pkg;

    // datapath width
    localparam int XLEN = 32;

    // architectural register address width
    localparam int REG_W = 5;

    // execution lanes
    localparam int NUM_LANES  = 4;
    localparam int LANE_IDX_W = $clog2(NUM_LANES);

    // reorder buffer geometry
    localparam int ROB_DEPTH = 8;
    localparam int ROB_IDX_W = $clog2(ROB_DEPTH);

    // running commit order number, wraps around
    localparam int ORDER_W = 16;

    // cycles from capture to bus request for a multiply
    localparam int MUL_LATENCY = 6;

    // lane countdown width, must hold MUL_LATENCY
    localparam int CNT_W = $clog2(MUL_LATENCY + 1);

    // micro-op operations
    // results are truncated to XLEN bits
    typedef enum logic [2:0] {
        // a + b
        OP_ADD = 3'd0,
        // a - b
        OP_SUB = 3'd1,
        // a & b
        OP_AND = 3'd2,
        // a ^ b
        OP_XOR = 3'd3,
        // a << b[4:0]
        OP_SLL = 3'd4,
        // low half of a * b
        OP_MUL = 3'd5
    } alu_op_e;

endpackage : ooo_pkg
